// ==== build.f ====
+incdir+logic
logic/ls_pkg.sv
logic/ls_buffer.sv
logic/ls_data_mem.sv
logic/ls_unit.sv
sim/tb_ls_unit.sv

// ==== Makefile ====
BIN := obj_dir/Vtb_ls_unit

.PHONY: all run check clean

all: $(BIN)

$(BIN): build.f logic/ls_consts.svh logic/ls_pkg.sv logic/ls_buffer.sv \
		logic/ls_data_mem.sv logic/ls_unit.sv sim/tb_ls_unit.sv
	verilator --binary --timing --assert -Wno-fatal -f build.f --top-module tb_ls_unit

run: $(BIN)
	./$(BIN) | tee sim.log
	grep -qx "sim passed" sim.log

check:
	grep -qx "sim passed" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== sim/tb_ls_unit.sv ====
`timescale 1ns/1ps
`include "ls_consts.svh"

module tb_ls_unit;

    typedef struct packed {
        logic [`LS_TAG_BITS-1:0] tag;
        logic                    is_store;
        logic [`LS_XLEN-1:0]     value;
    } exp_t;

    logic                    clk = 1'b0;
    logic                    rst_n;
    ls_pkg::ls_issue_t       issue;
    ls_pkg::cdb_bcast_t      cdb [`LS_CDB_PORTS];
    logic [`LS_TAG_BITS-1:0] rob_head;
    logic                    flush;
    logic                    full;
    ls_pkg::ls_result_t      result;

    // byte model of the 1 KiB the DUT decodes, and results still owed in issue order
    logic [7:0]              mdl [1024];
    exp_t                    exp_q [$];
    exp_t                    got;
    logic                    follow;
    logic [31:0]             seed = 32'ha014;
    logic [`LS_TAG_BITS-1:0] tag_ctr = '0;
    int                      errors = 0;
    int                      err_mark = 0;
    int                      n_pass = 0;
    int                      n_fail = 0;

    ls_unit dut_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .issue    (issue),
        .cdb      (cdb),
        .rob_head (rob_head),
        .flush    (flush),
        .full     (full),
        .result   (result)
    );

    always #20 clk = ~clk;

    function automatic logic [31:0] next_rand();
        seed ^= seed << 13;
        seed ^= seed >> 17;
        seed ^= seed << 5;
        return seed;
    endfunction

    function automatic logic [`LS_TAG_BITS-1:0] next_tag();
        tag_ctr = (tag_ctr == '1) ? 5'd1 : tag_ctr + 5'd1;
        return tag_ctr;
    endfunction

    // bytes touched by an access
    function automatic int size_of(input ls_pkg::mem_op_t op);
        case (op)
            ls_pkg::op_lb, ls_pkg::op_lbu, ls_pkg::op_sb: return 1;
            ls_pkg::op_lh, ls_pkg::op_lhu, ls_pkg::op_sh: return 2;
            default: return 4;
        endcase
    endfunction

    // aligned address inside the first 16 words
    function automatic logic [9:0] pick_addr(input ls_pkg::mem_op_t op);
        logic [9:0] a;
        a = 10'(next_rand() & 32'h3f);
        return a & ~10'(size_of(op) - 1);
    endfunction

    task automatic tick();
        @(negedge clk);
        issue.valid = 1'b0;
        flush       = 1'b0;
        foreach (cdb[p]) begin
            cdb[p] = '0;
        end
        // the oldest owed result stands in for the ROB head
        if (follow && exp_q.size() != 0) begin
            rob_head = exp_q[0].tag;
        end
    endtask

    task automatic expect_eq(input string name, input logic [31:0] val, input logic [31:0] want);
        assert (val === want) else begin
            $display("Mismatch %s: got %h expected %h", name, val, want);
            errors++;
        end
    endtask

    // base and data are the operand values, broadcast later when their tag is nonzero
    task automatic put(
        input ls_pkg::mem_op_t         op,
        input logic [`LS_TAG_BITS-1:0] rtag,
        input logic [`LS_TAG_BITS-1:0] btag,
        input logic [31:0]             base,
        input logic [`LS_TAG_BITS-1:0] dtag,
        input logic [31:0]             data,
        input logic [9:0]              a
    );
        exp_t        e;
        logic [31:0] want;
        int          n;
        n = 0;
        while (full && n < 100) begin
            tick();
            n++;
        end
        if (full) begin
            $display("timeout: buffer still full after %0d cycles", n);
            errors++;
        end
        want       = next_rand();
        want[9:0]  = a;
        issue.valid    = 1'b1;
        issue.op       = op;
        issue.rob_tag  = rtag;
        issue.base_tag = btag;
        issue.base_val = (btag != '0) ? next_rand() : base;
        issue.data_tag = dtag;
        issue.data_val = (dtag != '0) ? next_rand() : data;
        issue.imm      = want - base;
        e.tag      = rtag;
        e.is_store = op inside {ls_pkg::op_sb, ls_pkg::op_sh, ls_pkg::op_sw};
        e.value    = '0;
        for (int k = 0; k < size_of(op); k++) begin
            if (e.is_store) begin
                mdl[a + 10'(k)] = data[8*k +: 8];
            end else begin
                e.value[8*k +: 8] = mdl[a + 10'(k)];
            end
        end
        if (op == ls_pkg::op_lb) e.value = {{24{e.value[7]}}, e.value[7:0]};
        if (op == ls_pkg::op_lh) e.value = {{16{e.value[15]}}, e.value[15:0]};
        exp_q.push_back(e);
        tick();
    endtask

    task automatic drain(input string what);
        int n;
        n = 0;
        while (exp_q.size() != 0 && n < 200) begin
            tick();
            n++;
        end
        if (exp_q.size() != 0) begin
            $display("timeout: %0d results never arrived in %s", exp_q.size(), what);
            errors++;
            exp_q.delete();
        end
    endtask

    task automatic finish_test(input string name);
        if (errors == err_mark) begin
            n_pass++;
            $display("test %s: ok", name);
        end else begin
            n_fail++;
            $display("test %s: %0d errors", name, errors - err_mark);
        end
        err_mark = errors;
    endtask

    always @(negedge clk) begin
        if (rst_n && result.valid) begin
            if (exp_q.size() == 0) begin
                $display("unexpected result for rob tag %h", result.rob_tag);
                errors++;
            end else begin
                got = exp_q.pop_front();
                expect_eq("result.rob_tag", result.rob_tag, got.tag);
                expect_eq("result.is_store", result.is_store, got.is_store);
                expect_eq("result.value", result.value, got.value);
            end
        end
    end

    initial begin
        ls_pkg::mem_op_t op;
        logic [4:0]      t;
        logic [31:0]     b;
        logic [31:0]     d;
        logic [9:0]      a;
        rst_n    = 1'b0;
        issue    = '0;
        rob_head = '0;
        flush    = 1'b0;
        follow   = 1'b1;
        foreach (cdb[p]) begin
            cdb[p] = '0;
        end
        repeat (3) @(negedge clk);
        rst_n = 1'b1;
        tick();

        // fill the region, then read it back with every load kind
        for (int i = 0; i < 16; i++) begin
            put(ls_pkg::op_sw, next_tag(), '0, next_rand(), '0, next_rand(), 10'(i * 4));
        end
        for (int i = 0; i < 24; i++) begin
            op = ls_pkg::mem_op_t'(3'(next_rand() % 5));
            put(op, next_tag(), '0, next_rand(), '0, '0, pick_addr(op));
        end
        drain("ready loads");
        finish_test("ready loads");

        for (int i = 0; i < 12; i++) begin
            op = ls_pkg::mem_op_t'(3'(5 + next_rand() % 3));
            a  = pick_addr(op);
            put(op, next_tag(), '0, next_rand(), '0, next_rand(), a);
            put(ls_pkg::op_lw, next_tag(), '0, next_rand(), '0, '0, a & 10'h3fc);
        end
        drain("partial stores");
        finish_test("partial stores");

        // base tag woken on each port in turn
        for (int p = 0; p < `LS_CDB_PORTS; p++) begin
            b = next_rand();
            put(ls_pkg::op_lw, next_tag(), 5'd8, b, '0, '0, pick_addr(ls_pkg::op_lw));
            repeat (3) tick();
            expect_eq("pending results", exp_q.size(), 1);
            cdb[p] = '{tag: 5'd8, value: b};
            tick();
            drain("base wakeup");
        end
        b = next_rand();
        d = next_rand();
        a = pick_addr(ls_pkg::op_sw);
        put(ls_pkg::op_sw, next_tag(), 5'd9, b, 5'd10, d, a);
        repeat (3) tick();
        expect_eq("pending results", exp_q.size(), 1);
        cdb[3] = '{tag: 5'd9, value: b};
        cdb[0] = '{tag: 5'd10, value: d};
        tick();
        put(ls_pkg::op_lw, next_tag(), '0, next_rand(), '0, '0, a);
        // broadcast in the issue cycle; the higher port with the same tag loses
        b = next_rand();
        cdb[1] = '{tag: 5'd11, value: b};
        cdb[2] = '{tag: 5'd11, value: ~b};
        put(ls_pkg::op_lw, next_tag(), 5'd11, b, '0, '0, pick_addr(ls_pkg::op_lw));
        drain("wakeup");
        finish_test("operand wakeup");

        follow   = 1'b0;
        rob_head = '0;
        t = next_tag();
        a = pick_addr(ls_pkg::op_sw);
        put(ls_pkg::op_sw, t, '0, next_rand(), '0, next_rand(), a);
        put(ls_pkg::op_lw, next_tag(), '0, next_rand(), '0, '0, a);
        put(ls_pkg::op_lbu, next_tag(), '0, next_rand(), '0, '0, pick_addr(ls_pkg::op_lbu));
        repeat (8) tick();
        expect_eq("pending results", exp_q.size(), 3);
        rob_head = t;
        drain("store hold");
        follow = 1'b1;
        finish_test("store hold");

        b = next_rand();
        for (int i = 0; i < `LS_DEPTH; i++) begin
            put(ls_pkg::op_lw, next_tag(), 5'd12, b, '0, '0, pick_addr(ls_pkg::op_lw));
        end
        expect_eq("full", full, 1);
        // ninth issue, ready at once, must bounce off the full buffer
        issue         = '0;
        issue.valid   = 1'b1;
        issue.rob_tag = next_tag();
        tick();
        expect_eq("full", full, 1);
        expect_eq("pending results", exp_q.size(), `LS_DEPTH);
        cdb[2] = '{tag: 5'd12, value: b};
        tick();
        drain("full");
        repeat (4) tick();
        expect_eq("full", full, 0);
        finish_test("full");

        // a full buffer of waiting loads is emptied by the flush
        b = next_rand();
        for (int i = 0; i < `LS_DEPTH; i++) begin
            put(ls_pkg::op_lw, next_tag(), 5'd13, b, '0, '0, pick_addr(ls_pkg::op_lw));
        end
        expect_eq("full", full, 1);
        flush = 1'b1;
        exp_q.delete();
        tick();
        expect_eq("full", full, 0);

        // the ready load is on its way to memory when the flush lands
        put(ls_pkg::op_lw, next_tag(), '0, next_rand(), '0, '0, pick_addr(ls_pkg::op_lw));
        put(ls_pkg::op_lw, next_tag(), 5'd13, next_rand(), '0, '0, pick_addr(ls_pkg::op_lw));
        flush = 1'b1;
        exp_q.delete();
        tick();
        cdb[0] = '{tag: 5'd13, value: '0};
        repeat (10) tick();
        put(ls_pkg::op_lhu, next_tag(), '0, next_rand(), '0, '0, pick_addr(ls_pkg::op_lhu));
        drain("after flush");
        finish_test("flush");

        $display("tests passed %0d failed %0d", n_pass, n_fail);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// ==== logic/ls_unit.sv ====
`timescale 1ns/1ps
`include "ls_consts.svh"

module ls_unit (
    input  logic                    clk,
    input  logic                    rst_n,
    input  ls_pkg::ls_issue_t       issue,
    input  ls_pkg::cdb_bcast_t      cdb [`LS_CDB_PORTS],
    input  logic [`LS_TAG_BITS-1:0] rob_head,
    input  logic                    flush,
    output logic                    full,
    output ls_pkg::ls_result_t      result
);

    // buffer to memory dispatch
    ls_pkg::ls_access_t access;

    ls_buffer buffer_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .issue    (issue),
        .cdb      (cdb),
        .rob_head (rob_head),
        .flush    (flush),
        .full     (full),
        .access   (access)
    );

    ls_data_mem mem_i (
        .clk    (clk),
        .rst_n  (rst_n),
        .access (access),
        .flush  (flush),
        .result (result)
    );

endmodule

// ==== logic/ls_data_mem.sv ====
`timescale 1ns/1ps
`include "ls_consts.svh"

module ls_data_mem (
    input  logic               clk,
    input  logic               rst_n,
    input  ls_pkg::ls_access_t access,
    input  logic               flush,
    output ls_pkg::ls_result_t result
);

    logic [`LS_XLEN-1:0]           mem [`LS_MEM_WORDS];

    logic [`LS_MEM_WORDS_BITS-1:0] idx;
    logic [1:0]                    ofs;
    logic [`LS_XLEN-1:0]           word;
    logic [7:0]                    byte_sel;
    logic [15:0]                   half_sel;
    logic [`LS_XLEN-1:0]           load_val;
    logic [`LS_XLEN-1:0]           lane_data;
    logic [3:0]                    lane_en;
    logic                          do_access;
    logic                          is_st;

    logic                          res_valid;
    ls_pkg::ls_result_t            res_q;

    assign idx       = access.addr[`LS_MEM_WORDS_BITS+1:2];
    assign ofs       = access.addr[1:0];
    assign word      = mem[idx];
    assign is_st     = ls_pkg::is_store(access.op);
    // an access still in flight when the flush arrives is dropped
    assign do_access = access.valid && !flush;

    always_comb begin
        byte_sel = word[{ofs, 3'b000} +: 8];
        half_sel = word[{ofs[1], 4'b0000} +: 16];

        case (access.op)
            ls_pkg::op_lb:  load_val = {{(`LS_XLEN-8){byte_sel[7]}}, byte_sel};
            ls_pkg::op_lbu: load_val = {{(`LS_XLEN-8){1'b0}}, byte_sel};
            ls_pkg::op_lh:  load_val = {{(`LS_XLEN-16){half_sel[15]}}, half_sel};
            ls_pkg::op_lhu: load_val = {{(`LS_XLEN-16){1'b0}}, half_sel};
            default:        load_val = word;
        endcase

        // store data is replicated so every lane carries the right bytes
        case (access.op)
            ls_pkg::op_sb: begin
                lane_en   = 4'b0001 << ofs;
                lane_data = {4{access.store_data[7:0]}};
            end
            ls_pkg::op_sh: begin
                lane_en   = ofs[1] ? 4'b1100 : 4'b0011;
                lane_data = {2{access.store_data[15:0]}};
            end
            ls_pkg::op_sw: begin
                lane_en   = 4'b1111;
                lane_data = access.store_data;
            end
            default: begin
                lane_en   = 4'b0000;
                lane_data = access.store_data;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (do_access && is_st) begin
            for (int b = 0; b < 4; b++) begin
                if (lane_en[b]) begin
                    mem[idx][b*8 +: 8] <= lane_data[b*8 +: 8];
                end
            end
        end

        if (do_access) begin
            res_q <= '{
                valid:    1'b1,
                is_store: is_st,
                rob_tag:  access.rob_tag,
                value:    is_st ? '0 : load_val
            };
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            res_valid <= 1'b0;
        end else begin
            res_valid <= do_access;
        end
    end

    always_comb begin
        result       = res_q;
        result.valid = res_valid;
    end

endmodule

// ==== logic/ls_buffer.sv ====
`timescale 1ns/1ps
`include "ls_consts.svh"

module ls_buffer (
    input  logic                     clk,
    input  logic                     rst_n,
    input  ls_pkg::ls_issue_t        issue,
    input  ls_pkg::cdb_bcast_t       cdb [`LS_CDB_PORTS],
    input  logic [`LS_TAG_BITS-1:0]  rob_head,
    input  logic                     flush,
    output logic                     full,
    output ls_pkg::ls_access_t       access
);

    logic [`LS_DEPTH-1:0]      busy;
    logic [`LS_DEPTH_BITS-1:0] head;
    logic [`LS_DEPTH_BITS-1:0] tail;

    ls_pkg::ls_issue_t         ent [`LS_DEPTH];
    logic [`LS_XLEN-1:0]       addr [`LS_DEPTH];

    ls_pkg::cdb_bcast_t        base_nxt [`LS_DEPTH];
    ls_pkg::cdb_bcast_t        data_nxt [`LS_DEPTH];
    ls_pkg::cdb_bcast_t        in_base;
    ls_pkg::cdb_bcast_t        in_data;

    logic                      accept;
    logic                      dispatch;
    logic                      acc_valid;
    ls_pkg::ls_access_t        acc_q;

    // operand after this cycle's broadcast; lowest matching port wins
    function automatic ls_pkg::cdb_bcast_t snoop(
        input ls_pkg::cdb_bcast_t opnd,
        input ls_pkg::cdb_bcast_t bus [`LS_CDB_PORTS]
    );
        ls_pkg::cdb_bcast_t res;
        res = opnd;
        if (opnd.tag != '0) begin
            for (int p = `LS_CDB_PORTS - 1; p >= 0; p--) begin
                if (bus[p].tag == opnd.tag) begin
                    res.tag   = '0;
                    res.value = bus[p].value;
                end
            end
        end
        return res;
    endfunction

    assign full   = busy[tail];
    assign accept = issue.valid && !full;

    always_comb begin
        for (int i = 0; i < `LS_DEPTH; i++) begin
            base_nxt[i] = snoop('{tag: ent[i].base_tag, value: ent[i].base_val}, cdb);
            data_nxt[i] = snoop('{tag: ent[i].data_tag, value: ent[i].data_val}, cdb);
        end
        // an issue also sees the broadcast of its own cycle
        in_base = snoop('{tag: issue.base_tag, value: issue.base_val}, cdb);
        in_data = snoop('{tag: issue.data_tag, value: issue.data_val}, cdb);
    end

    // stores wait at the head until they are the oldest in the ROB
    assign dispatch = busy[head]
                   && ent[head].base_tag == '0
                   && ent[head].data_tag == '0
                   && (!ls_pkg::is_store(ent[head].op) || ent[head].rob_tag == rob_head);

    always_ff @(posedge clk) begin
        for (int i = 0; i < `LS_DEPTH; i++) begin
            if (busy[i]) begin
                ent[i].base_tag <= base_nxt[i].tag;
                ent[i].base_val <= base_nxt[i].value;
                ent[i].data_tag <= data_nxt[i].tag;
                ent[i].data_val <= data_nxt[i].value;
                addr[i]         <= base_nxt[i].value + ent[i].imm;
            end
        end

        if (accept) begin
            ent[tail]          <= issue;
            ent[tail].base_tag <= in_base.tag;
            ent[tail].base_val <= in_base.value;
            ent[tail].data_tag <= in_data.tag;
            ent[tail].data_val <= in_data.value;
            addr[tail]         <= in_base.value + issue.imm;
        end

        if (dispatch) begin
            acc_q <= '{
                valid:      1'b1,
                op:         ent[head].op,
                rob_tag:    ent[head].rob_tag,
                addr:       addr[head],
                store_data: ent[head].data_val
            };
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy      <= '0;
            head      <= '0;
            tail      <= '0;
            acc_valid <= 1'b0;
        end else if (flush) begin
            busy      <= '0;
            head      <= '0;
            tail      <= '0;
            acc_valid <= 1'b0;
        end else begin
            acc_valid <= dispatch;
            // accept needs a free tail and dispatch a busy head, so the slots differ
            if (accept) begin
                busy[tail] <= 1'b1;
                tail       <= tail + 1'b1;
            end
            if (dispatch) begin
                busy[head] <= 1'b0;
                head       <= head + 1'b1;
            end
        end
    end

    always_comb begin
        access       = acc_q;
        access.valid = acc_valid;
    end

endmodule

// ==== logic/ls_pkg.sv ====
`include "ls_consts.svh"

package ls_pkg;

    // loads take the five low codes, stores the top three
    typedef enum logic [2:0] {
        op_lb  = 3'b000,
        op_lh  = 3'b001,
        op_lw  = 3'b010,
        op_lbu = 3'b011,
        op_lhu = 3'b100,
        op_sb  = 3'b101,
        op_sh  = 3'b110,
        op_sw  = 3'b111
    } mem_op_t;

    typedef struct packed {
        logic                    valid;
        mem_op_t                 op;
        logic [`LS_TAG_BITS-1:0] rob_tag;
        logic [`LS_TAG_BITS-1:0] base_tag;
        logic [`LS_XLEN-1:0]     base_val;
        logic [`LS_TAG_BITS-1:0] data_tag;
        logic [`LS_XLEN-1:0]     data_val;
        logic [`LS_XLEN-1:0]     imm;
    } ls_issue_t;

    // tag zero means the port is idle
    typedef struct packed {
        logic [`LS_TAG_BITS-1:0] tag;
        logic [`LS_XLEN-1:0]     value;
    } cdb_bcast_t;

    typedef struct packed {
        logic                    valid;
        mem_op_t                 op;
        logic [`LS_TAG_BITS-1:0] rob_tag;
        logic [`LS_XLEN-1:0]     addr;
        logic [`LS_XLEN-1:0]     store_data;
    } ls_access_t;

    typedef struct packed {
        logic                    valid;
        logic                    is_store;
        logic [`LS_TAG_BITS-1:0] rob_tag;
        logic [`LS_XLEN-1:0]     value;
    } ls_result_t;

    function automatic logic is_store(input mem_op_t op);
        return op inside {op_sb, op_sh, op_sw};
    endfunction

endpackage

// ==== logic/ls_consts.svh ====
`ifndef LS_CONSTS_SVH
`define LS_CONSTS_SVH

// load/store buffer geometry
`define LS_DEPTH_BITS 3
`define LS_DEPTH (1 << `LS_DEPTH_BITS)

`define LS_TAG_BITS 5
`define LS_XLEN 32
`define LS_CDB_PORTS 4

// word-organised data memory
`define LS_MEM_WORDS_BITS 8
`define LS_MEM_WORDS (1 << `LS_MEM_WORDS_BITS)

`endif
